// File: dv/ecc_tb_util.svh
`ifndef ECC_TB_UTIL_SVH
`define ECC_TB_UTIL_SVH

// ==============================
// Stimulus kinds and counters
// ==============================

typedef enum int {
    KIND_CLEAN      = 0,
    KIND_DATA_FLIP  = 1,
    KIND_CHECK_FLIP = 2,
    KIND_DOUBLE     = 3,
    KIND_BYPASS     = 4
} test_kind_e;

localparam int CODE_WIDTH = DATA_WIDTH + PARITY_WIDTH;   // Data bits, then check bits

int error_count    = 0;
int beats_sent     = 0;
int beats_checked  = 0;
int beats_received = 0;     // Every output transfer, expected or not
int tests_run      = 0;
int tests_failed   = 0;

logic [31:0] lfsr_state;
parity_t     col_table [DATA_WIDTH];

// ==============================
// Random source
// ==============================

// Fibonacci LFSR with taps 32, 22, 2, 1
function automatic logic rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic int unsigned rand_below(input int unsigned limit);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 10; i++) begin
        v = {v[30:0], rand_bit()};
    end
    return v % limit;
endfunction

function automatic data_t rand_data();
    data_t d;
    d = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        d = {d[DATA_WIDTH-2:0], rand_bit()};
    end
    return d;
endfunction

// ==============================
// Reference code
// ==============================

// Walk the Hamming positions from 3 up and skip the powers of two
function automatic parity_t ref_column(input int idx);
    int         pos;
    int         seen;
    logic [6:0] low;
    logic       top;
    pos  = 2;
    seen = -1;
    while (seen < idx) begin
        pos++;
        if ((pos & (pos - 1)) != 0)
            seen++;
    end
    low = pos[6:0];
    top = (($countones(low) % 2) == 0) ? 1'b1 : 1'b0;   // Odd column weight
    return {top, low};
endfunction

task automatic build_columns();
    for (int i = 0; i < DATA_WIDTH; i++) begin
        col_table[i] = ref_column(i);
    end
endtask

function automatic parity_t ref_encode(input data_t d);
    parity_t p;
    p = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (d[i])
            p = p ^ col_table[i];
    end
    return p;
endfunction

// ==============================
// Error injection
// ==============================

task automatic flip_position(inout raw_beat_t raw, input int unsigned pos);
    if (pos < DATA_WIDTH)
        raw.data = raw.data ^ (data_t'(1) << pos);
    else
        raw.parity = raw.parity ^ (parity_t'(1) << (pos - DATA_WIDTH));
endtask

// Builds one received beat and the output that the code must give for it
task automatic make_beat(input test_kind_e kind, output raw_beat_t raw,
                         output out_beat_t exp);
    data_t       d;
    int unsigned a;
    int unsigned b;
    d          = rand_data();
    raw.data   = d;
    raw.parity = ref_encode(d);
    raw.bypass = 1'b0;
    exp.data     = d;
    exp.sbit_err = 1'b0;
    exp.dbit_err = 1'b0;
    a = rand_below(CODE_WIDTH);
    b = rand_below(CODE_WIDTH - 1);
    if (b >= a)
        b++;                                    // Second flip never hits the first
    case (kind)
        KIND_DATA_FLIP: begin
            flip_position(raw, rand_below(DATA_WIDTH));
            exp.sbit_err = 1'b1;
        end
        KIND_CHECK_FLIP: begin
            flip_position(raw, DATA_WIDTH + rand_below(PARITY_WIDTH));
            exp.sbit_err = 1'b1;
        end
        KIND_DOUBLE: begin
            flip_position(raw, a);
            flip_position(raw, b);
            exp.data     = raw.data;            // Left uncorrected
            exp.dbit_err = 1'b1;
        end
        KIND_BYPASS: begin
            flip_position(raw, a);
            if (rand_bit())
                flip_position(raw, b);
            raw.bypass = 1'b1;
            exp.data   = raw.data;
        end
        default: ;
    endcase
    exp.parity = ref_encode(raw.data);          // Output carries the recomputed bits
endtask

`endif

// File: dv/ecc_tb.sv
`timescale 1ns/1ps

module ecc_tb
    import ecc_pkg::*;
();

    localparam int WAIT_LIMIT = 500;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    raw_beat_t in_beat;
    logic      out_valid;
    logic      out_ready;
    out_beat_t out_beat;

    bit        bp_mode;
    bit        timed_out;              // Set once a wait gives up, stops the sequence
    out_beat_t exp_q [$];                  // Expected beats in acceptance order

    `include "ecc_tb_util.svh"

    ecc_108_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #4 clk = ~clk;

    // ==============================
    // Scoreboard
    // ==============================

    always @(posedge clk) begin : scoreboard
        out_beat_t exp;
        if (!rst && out_valid && out_ready) begin
            beats_received++;
            if (exp_q.size() == 0) begin
                $display("An output beat arrived with no input beat pending");
                error_count++;
            end else begin
                exp = exp_q.pop_front();
                beats_checked++;
                a_data: assert (out_beat.data == exp.data) else begin
                    $display("[ERROR] out_beat.data: got %h, expected %h",
                             out_beat.data, exp.data);
                    error_count++;
                end
                a_parity: assert (out_beat.parity == exp.parity) else begin
                    $display("[ERROR] out_beat.parity: got %h, expected %h",
                             out_beat.parity, exp.parity);
                    error_count++;
                end
                a_sbit: assert (out_beat.sbit_err == exp.sbit_err) else begin
                    $display("[ERROR] out_beat.sbit_err: got %h, expected %h",
                             out_beat.sbit_err, exp.sbit_err);
                    error_count++;
                end
                a_dbit: assert (out_beat.dbit_err == exp.dbit_err) else begin
                    $display("[ERROR] out_beat.dbit_err: got %h, expected %h",
                             out_beat.dbit_err, exp.dbit_err);
                    error_count++;
                end
            end
        end
    end

    // ==============================
    // Driver tasks
    // ==============================

    task automatic report_timeout(input string why);
        $display("%s", why);
        error_count++;
        timed_out = 1'b1;
    endtask

    // One clock edge, with a fresh random out_ready under back-pressure
    task automatic tick();
        @(posedge clk);
        if (bp_mode)
            out_ready <= rand_bit();
    endtask

    // Called on a rising edge, returns on the edge where the beat transferred
    task automatic send_beat(input raw_beat_t raw, input out_beat_t exp);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_beat  <= raw;
        tick();
        while (!in_ready && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("Timed out waiting for in_ready to accept a beat");
            else
                tick();
        end
        if (!timed_out) begin
            exp_q.push_back(exp);
            beats_sent++;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        in_valid <= 1'b0;
        while (exp_q.size() != 0 && !timed_out) begin
            tick();
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("Timed out waiting for the pipeline to deliver its beats");
        end
        bp_mode = 1'b0;
        out_ready <= 1'b1;
    endtask

    task automatic run_test(input string name, input test_kind_e kind, input int beats,
                            input bit backpressure);
        raw_beat_t  raw;
        out_beat_t  exp;
        test_kind_e k;
        int         errors_before;
        if (timed_out)
            return;
        errors_before = error_count;
        bp_mode = backpressure;
        for (int n = 0; n < beats && !timed_out; n++) begin
            k = backpressure ? test_kind_e'(rand_below(5)) : kind;   // Mixed kinds
            make_beat(k, raw, exp);
            send_beat(raw, exp);
        end
        drain_outputs();
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: %0d beats, no errors", name, beats);
        end else begin
            tests_failed++;
            $display("Test %s: %0d beats, %0d errors", name, beats,
                     error_count - errors_before);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_beat    = '0;
        out_ready  = 1'b1;
        bp_mode    = 1'b0;
        timed_out  = 1'b0;
        lfsr_state = 32'head410b5;
        build_columns();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        tick();
        a_reset: assert (in_ready && !out_valid) else begin
            $display("After reset in_ready was low or out_valid was high");
            error_count++;
        end

        run_test("clean_words", KIND_CLEAN, 40, 1'b0);
        run_test("single_data_flip", KIND_DATA_FLIP, 60, 1'b0);
        run_test("single_check_flip", KIND_CHECK_FLIP, 30, 1'b0);
        run_test("double_flip", KIND_DOUBLE, 60, 1'b0);
        run_test("bypass", KIND_BYPASS, 30, 1'b0);
        run_test("back_pressure", KIND_CLEAN, 200, 1'b1);

        // Every accepted beat came out exactly once
        a_count: assert (beats_received == beats_sent) else begin
            $display("Sent %0d beats but received %0d", beats_sent, beats_received);
            error_count++;
        end

        $display("Tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
                 tests_run, tests_failed, beats_checked, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: rtl/ecc_108_top.sv
`timescale 1ns/1ps

module ecc_108_top
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  raw_beat_t in_beat,
    output logic      out_valid,
    input  logic      out_ready,
    output out_beat_t out_beat
);

    // ==============================
    // Link between the two stages
    // ==============================

    logic      syn_valid;
    logic      syn_ready;
    syn_beat_t syn_beat;

    // Stage one forms the syndrome
    ecc_syndrome_stage u_syndrome (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .syn_valid (syn_valid),
        .syn_ready (syn_ready),
        .syn_beat  (syn_beat)
    );

    // Stage two decodes and corrects
    ecc_correct_stage u_correct (
        .clk       (clk),
        .rst       (rst),
        .syn_valid (syn_valid),
        .syn_ready (syn_ready),
        .syn_beat  (syn_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

endmodule

// File: rtl/ecc_correct_stage.sv
`timescale 1ns/1ps

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      syn_valid,
    output logic      syn_ready,
    input  syn_beat_t syn_beat,
    output logic      out_valid,
    input  logic      out_ready,
    output out_beat_t out_beat
);

    data_t     flip_mask;
    err_kind_e err_kind;
    data_t     data_fixed;
    logic      sbit_err;
    logic      dbit_err;
    logic      accept;

    // ==============================
    // Syndrome decode
    // ==============================

    always_comb begin
        parity_t syn;
        syn       = syn_beat.syndrome;
        flip_mask = '0;
        if (syn == '0) begin
            err_kind = ERR_NONE;
        end else if ((syn & (syn - 1'b1)) == '0) begin
            err_kind = ERR_SINGLE;     // Only a stored check bit flipped
        end else begin
            err_kind = ERR_DOUBLE;
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (syn == ecc_column(i)) begin
                    flip_mask[i] = 1'b1;
                    err_kind     = ERR_SINGLE;
                end
            end
        end
    end

    // Bypass passes the word untouched and reports nothing
    assign data_fixed = syn_beat.bypass ? syn_beat.data : syn_beat.data ^ flip_mask;
    assign sbit_err   = !syn_beat.bypass && (err_kind == ERR_SINGLE);
    assign dbit_err   = !syn_beat.bypass && (err_kind == ERR_DOUBLE);

    // ==============================
    // Output slot
    // ==============================

    assign syn_ready = !out_valid || out_ready;
    assign accept    = syn_valid && syn_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_beat.data     <= data_fixed;
            out_beat.parity   <= syn_beat.parity;   // Recomputed, not the stored bits
            out_beat.sbit_err <= sbit_err;
            out_beat.dbit_err <= dbit_err;
        end
    end

    // Odd-weight columns keep the two error classes apart
    a_flags_excl: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> !(out_beat.sbit_err && out_beat.dbit_err)
    ) else $error("sbit_err and dbit_err both set");

    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else $error("out_beat changed under back-pressure");

endmodule

// File: rtl/ecc_pkg.sv
package ecc_pkg;

    // ==============================
    // Widths
    // ==============================

    localparam int DATA_WIDTH   = 108;
    localparam int PARITY_WIDTH = 8;

    // Hamming positions use seven bits, bit 7 is the overall weight bit
    localparam int POS_WIDTH = PARITY_WIDTH - 1;
    localparam int POS_LIMIT = 1 << POS_WIDTH;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;

    // ==============================
    // Error classification
    // ==============================

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_SINGLE = 2'd1,
        ERR_DOUBLE = 2'd2
    } err_kind_e;

    // ==============================
    // Beats on the three links
    // ==============================

    typedef struct packed {
        data_t   data;
        parity_t parity;      // Check bits stored with the word
        logic    bypass;
    } raw_beat_t;

    typedef struct packed {
        data_t   data;
        parity_t parity;      // Recomputed from the received data
        parity_t syndrome;
        logic    bypass;
    } syn_beat_t;

    typedef struct packed {
        data_t   data;        // Corrected unless bypass was set
        parity_t parity;
        logic    sbit_err;
        logic    dbit_err;
    } out_beat_t;

    // Column of data bit idx in the check matrix.
    // Data bits take the Hamming positions from 3 up, skipping powers of two.
    // The top bit makes the column weight odd, so any two columns XOR to an
    // even-weight syndrome that never matches a single-error column
    function automatic parity_t ecc_column(input int unsigned idx);
        int unsigned       pos;
        int unsigned       cnt;
        int unsigned       k;
        logic [POS_WIDTH-1:0] low;
        pos = 0;
        cnt = 0;
        for (k = 3; k < POS_LIMIT; k++) begin
            if ((k & (k - 1)) != 0) begin   // Not a power of two
                if (cnt == idx)
                    pos = k;
                cnt++;
            end
        end
        low = pos[POS_WIDTH-1:0];
        return {~^low, low};                // Set bit 7 on even popcount
    endfunction

endpackage

// File: rtl/ecc_syndrome_stage.sv
`timescale 1ns/1ps

module ecc_syndrome_stage
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  raw_beat_t in_beat,
    output logic      syn_valid,
    input  logic      syn_ready,
    output syn_beat_t syn_beat
);

    parity_t parity_calc;
    parity_t syndrome;
    logic    accept;

    // ==============================
    // Check-bit recompute
    // ==============================

    // Each data bit feeds every check bit that its column has set
    always_comb begin
        parity_t col;
        parity_calc = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            col = ecc_column(i);
            parity_calc = parity_calc ^ (col & {PARITY_WIDTH{in_beat.data[i]}});
        end
    end

    assign syndrome = parity_calc ^ in_beat.parity;

    // ==============================
    // Pipeline slot
    // ==============================

    // Slot can take a new beat when empty or when it drains this cycle
    assign in_ready = !syn_valid || syn_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            syn_valid <= 1'b0;
        end else if (accept) begin
            syn_valid <= 1'b1;
        end else if (syn_ready) begin
            syn_valid <= 1'b0;     // Beat left and nothing replaced it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            syn_beat.data     <= in_beat.data;
            syn_beat.parity   <= parity_calc;
            syn_beat.syndrome <= syndrome;
            syn_beat.bypass   <= in_beat.bypass;
        end
    end

    // A stalled beat stays put until stage two takes it
    a_syn_hold: assert property (
        @(posedge clk) disable iff (rst)
        syn_valid && !syn_ready |=> syn_valid && $stable(syn_beat)
    ) else $error("syn_beat changed while stalled");

endmodule

// File: run.sh
#!/bin/sh
# Builds the ECC testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ecc_tb -f sim.f -o ecc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/ecc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sim.f
+incdir+dv
rtl/ecc_pkg.sv
rtl/ecc_syndrome_stage.sv
rtl/ecc_correct_stage.sv
rtl/ecc_108_top.sv
dv/ecc_tb.sv
